// File: src/core_config.svh
// core-wide constants for the teaching pipeline, included by the packages and the RTL
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// pc width in instruction words
`define PC_W 9

// number of branch checkpoints in the pool
`define CHKP_NUM 2

// fetch address taken after an ecall commits
`define TRAP_VEC 9'h1f0

// architectural registers
`define NREGS 8

`endif

// File: src/isa_pkg.sv
// opcode and field layout of the 16-bit private encoding, imported by the pipeline stages
`include "core_config.svh"

package isa_pkg;

    typedef logic [15:0] instr_t;

    // field positions inside an instruction
    localparam int OPC_MSB   = 15;
    localparam int OPC_LSB   = 13;
    localparam int RD_MSB    = 12;
    localparam int RD_LSB    = 10;
    localparam int REG_W     = RD_MSB - RD_LSB + 1;
    localparam int IMM_W     = 10;
    // branch taken flag, target sits below it
    localparam int TAKEN_BIT = 9;
    localparam int TGT_MSB   = 8;

    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ALU   = 3'd1,
        OP_BR    = 3'd2,
        OP_JAL   = 3'd3,
        OP_FENCE = 3'd4,
        OP_CSR   = 3'd5,
        OP_ECALL = 3'd6
    } opcode_e;

    typedef logic [$clog2(`CHKP_NUM)-1:0] chkp_t;

endpackage

// File: src/pipe_ctrl_pkg.sv
// control encodings shared by the control unit and the fetch stage

package pipe_ctrl_pkg;

    // what fetch does with its pc on the next edge
    typedef enum logic [1:0] {
        NEXT_PC_KEEP  = 2'd0,
        NEXT_PC_PLUS1 = 2'd1,
        NEXT_PC_JUMP  = 2'd2
    } next_pc_sel_e;

    // which stage supplies the jump address
    typedef enum logic [1:0] {
        JUMP_DECODE = 2'd0,
        JUMP_EXEC   = 2'd1,
        JUMP_TRAP   = 2'd2
    } jump_src_e;

endpackage

// File: src/fetch_stage.sv
// fetch stage, owns the pc and the fetch-to-decode register
`timescale 1ns/1ps
`include "core_config.svh"

module fetch_stage (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  isa_pkg::instr_t            instr_i,
    input  logic                       stall_if_i,
    input  logic                       flush_if_i,
    input  pipe_ctrl_pkg::next_pc_sel_e next_pc_sel_i,
    input  pipe_ctrl_pkg::jump_src_e   jump_src_i,
    input  logic [`PC_W-1:0]           id_jal_target_i,
    input  logic [`PC_W-1:0]           ex_target_i,
    output logic [`PC_W-1:0]           fetch_pc_o,
    output logic                       if_valid_o,
    output logic [`PC_W-1:0]           if_pc_o,
    output isa_pkg::instr_t            if_instr_o
);
    import pipe_ctrl_pkg::*;

    logic [`PC_W-1:0] pc_q;
    logic [`PC_W-1:0] pc_d;
    logic [`PC_W-1:0] jump_pc;

    always_comb begin
        case (jump_src_i)
            JUMP_EXEC: jump_pc = ex_target_i;
            JUMP_TRAP: jump_pc = `TRAP_VEC;
            default:   jump_pc = id_jal_target_i;
        endcase
        case (next_pc_sel_i)
            NEXT_PC_PLUS1: pc_d = pc_q + 1'b1;
            NEXT_PC_JUMP:  pc_d = jump_pc;
            default:       pc_d = pc_q;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q       <= '0;
            if_valid_o <= 1'b0;
            if_pc_o    <= '0;
        end else begin
            pc_q <= pc_d;
            // a flushed fetch turns into a bubble, a stalled one keeps its slot
            if (flush_if_i) begin
                if_valid_o <= 1'b0;
            end else if (!stall_if_i) begin
                if_valid_o <= 1'b1;
                if_pc_o    <= pc_q;
            end
        end
    end

    // instruction word is payload only
    always_ff @(posedge clk_i) begin
        if (!flush_if_i && !stall_if_i) begin
            if_instr_o <= instr_i;
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

// File: src/decode_stage.sv
// decode stage, classifies the instruction, owns the checkpoint pool and the decode register
`timescale 1ns/1ps
`include "core_config.svh"

module decode_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  if_valid_i,
    input  logic [`PC_W-1:0]      if_pc_i,
    input  isa_pkg::instr_t       if_instr_i,
    input  logic                  stall_id_i,
    input  logic                  flush_id_i,
    input  logic                  do_checkpoint_i,
    input  logic                  do_recover_i,
    input  logic                  free_chkp_i,
    input  isa_pkg::chkp_t        recover_chkp_i,
    output logic                  id_jal_o,
    output logic [`PC_W-1:0]      id_jal_target_o,
    output logic                  id_is_br_o,
    output logic                  id_serial_o,
    output logic                  chkp_empty_o,
    output logic                  id_valid_o,
    output logic [`PC_W-1:0]      id_pc_o,
    output isa_pkg::instr_t       id_instr_o,
    output isa_pkg::chkp_t        id_chkp_o
);
    import isa_pkg::*;

    opcode_e             opc;
    logic [`CHKP_NUM-1:0] chkp_busy_q;
    chkp_t               alloc_idx;

    assign opc = opcode_e'(if_instr_i[OPC_MSB:OPC_LSB]);

    assign id_jal_o        = if_valid_i && (opc == OP_JAL);
    assign id_is_br_o      = if_valid_i && (opc == OP_BR);
    assign id_serial_o     = if_valid_i && ((opc == OP_FENCE) || (opc == OP_CSR));
    assign id_jal_target_o = if_instr_i[TGT_MSB:0];

    // pick the lowest free slot, descending loop so lower indices win
    always_comb begin
        alloc_idx = '0;
        for (int i = `CHKP_NUM - 1; i >= 0; i--) begin
            if (!chkp_busy_q[i]) begin
                alloc_idx = chkp_t'(i);
            end
        end
    end

    assign chkp_empty_o = &chkp_busy_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            chkp_busy_q <= '0;
        end else if (do_recover_i) begin
            // every branch still in flight is on the wrong path
            chkp_busy_q <= '0;
        end else begin
            if (free_chkp_i) begin
                chkp_busy_q[recover_chkp_i] <= 1'b0;
            end
            if (do_checkpoint_i) begin
                chkp_busy_q[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            id_valid_o <= 1'b0;
        end else begin
            // while stalled, execute sees a bubble
            id_valid_o <= if_valid_i && !flush_id_i && !stall_id_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_id_i) begin
            id_pc_o    <= if_pc_i;
            id_instr_o <= if_instr_i;
            id_chkp_o  <= alloc_idx;
        end
    end

endmodule

// File: src/exec_stage.sv
// execute stage, resolves branches against the not-taken prediction
`timescale 1ns/1ps
`include "core_config.svh"

module exec_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  id_valid_i,
    input  logic [`PC_W-1:0]      id_pc_i,
    input  isa_pkg::instr_t       id_instr_i,
    input  isa_pkg::chkp_t        id_chkp_i,
    input  logic                  flush_ex_i,
    output logic                  ex_valid_o,
    output logic                  ex_mispredict_o,
    output logic [`PC_W-1:0]      ex_target_o,
    output isa_pkg::chkp_t        ex_chkp_o,
    output logic [`PC_W-1:0]      ex_pc_o,
    output isa_pkg::instr_t       ex_instr_o
);
    import isa_pkg::*;

    opcode_e opc;

    assign opc = opcode_e'(id_instr_i[OPC_MSB:OPC_LSB]);

    // prediction is always not-taken, so any taken branch is a mispredict
    assign ex_mispredict_o = id_valid_i && (opc == OP_BR) && id_instr_i[TAKEN_BIT];
    assign ex_target_o     = id_instr_i[TGT_MSB:0];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i && !flush_ex_i;
        end
    end

    // checkpoint index travels with the branch so decode can free it
    always_ff @(posedge clk_i) begin
        ex_pc_o    <= id_pc_i;
        ex_instr_o <= id_instr_i;
        ex_chkp_o  <= id_chkp_i;
    end

endmodule

// File: src/commit_stage.sv
// commit stage, retires instructions and holds the architectural register file
`timescale 1ns/1ps
`include "core_config.svh"

module commit_stage (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        ex_valid_i,
    input  logic [`PC_W-1:0]            ex_pc_i,
    input  isa_pkg::instr_t             ex_instr_i,
    input  logic                        rf_we_i,
    output logic                        cm_valid_o,
    output logic                        cm_xcpt_o,
    output logic                        cm_serial_o,
    output logic                        cm_write_o,
    output logic [`PC_W-1:0]            commit_pc_o,
    output logic [isa_pkg::REG_W-1:0]   rf_waddr_o,
    output logic [isa_pkg::IMM_W-1:0]   rf_wdata_o
);
    import isa_pkg::*;

    instr_t          cm_instr_q;
    opcode_e         opc;
    logic [IMM_W-1:0] rf_q [`NREGS];

    assign opc = opcode_e'(cm_instr_q[OPC_MSB:OPC_LSB]);

    assign cm_xcpt_o   = cm_valid_o && (opc == OP_ECALL);
    assign cm_serial_o = cm_valid_o && ((opc == OP_FENCE) || (opc == OP_CSR));
    assign cm_write_o  = cm_valid_o && ((opc == OP_ALU) || (opc == OP_CSR));

    assign rf_waddr_o = cm_instr_q[RD_MSB:RD_LSB];
    assign rf_wdata_o = cm_instr_q[IMM_W-1:0];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            cm_valid_o <= 1'b0;
        end else begin
            // an excepting instruction drops the one right behind it
            cm_valid_o <= ex_valid_i && !cm_xcpt_o;
        end
    end

    always_ff @(posedge clk_i) begin
        commit_pc_o <= ex_pc_i;
        cm_instr_q  <= ex_instr_i;
        if (rf_we_i) begin
            rf_q[rf_waddr_o] <= rf_wdata_o;
        end
    end

endmodule

// File: src/control_unit.sv
// central pipeline control, decides stalls, flushes, next pc, checkpoints and rf writes
`timescale 1ns/1ps

module control_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        halt_i,
    input  logic                        id_jal_i,
    input  logic                        id_is_br_i,
    input  logic                        id_serial_i,
    input  logic                        chkp_empty_i,
    input  logic                        ex_valid_i,
    input  logic                        ex_mispredict_i,
    input  logic                        cm_valid_i,
    input  logic                        cm_xcpt_i,
    input  logic                        cm_serial_i,
    input  logic                        cm_write_i,
    output logic                        stall_if_o,
    output logic                        stall_id_o,
    output logic                        flush_if_o,
    output logic                        flush_id_o,
    output logic                        flush_ex_o,
    output pipe_ctrl_pkg::next_pc_sel_e next_pc_sel_o,
    output pipe_ctrl_pkg::jump_src_e    jump_src_o,
    output logic                        do_checkpoint_o,
    output logic                        do_recover_o,
    output logic                        free_chkp_o,
    output logic                        rf_we_o
);
    import pipe_ctrl_pkg::*;

    logic xcpt_q;
    logic xcpt_flush;
    logic serial_q;
    logic br_ex_q;
    logic br_done_q;

    // ecall at commit kills the younger ones now, the trap jump follows a cycle later
    assign xcpt_flush = cm_xcpt_i || xcpt_q;

    always_comb begin
        stall_if_o    = 1'b0;
        stall_id_o    = 1'b0;
        flush_if_o    = 1'b0;
        flush_id_o    = 1'b0;
        flush_ex_o    = 1'b0;
        next_pc_sel_o = NEXT_PC_PLUS1;
        jump_src_o    = JUMP_DECODE;
        if (xcpt_flush) begin
            flush_if_o    = 1'b1;
            flush_id_o    = 1'b1;
            flush_ex_o    = 1'b1;
            next_pc_sel_o = xcpt_q ? NEXT_PC_JUMP : NEXT_PC_KEEP;
            jump_src_o    = JUMP_TRAP;
        end else if (ex_mispredict_i) begin
            flush_if_o    = 1'b1;
            flush_id_o    = 1'b1;
            next_pc_sel_o = NEXT_PC_JUMP;
            jump_src_o    = JUMP_EXEC;
        end else if (id_serial_i || serial_q) begin
            // hold fetch until the fence or csr retires
            flush_if_o    = 1'b1;
            next_pc_sel_o = NEXT_PC_KEEP;
        end else if (id_jal_i) begin
            flush_if_o    = 1'b1;
            next_pc_sel_o = NEXT_PC_JUMP;
        end else if (id_is_br_i && chkp_empty_i) begin
            stall_if_o    = 1'b1;
            stall_id_o    = 1'b1;
            next_pc_sel_o = NEXT_PC_KEEP;
        end else if (halt_i) begin
            flush_if_o    = 1'b1;
            next_pc_sel_o = NEXT_PC_KEEP;
        end
    end

    assign do_checkpoint_o = id_is_br_i && !chkp_empty_i && !flush_id_o && !stall_id_o;
    // recovery on an exception too, any branch in flight is younger than the ecall
    assign do_recover_o    = ex_mispredict_i || xcpt_flush;
    // slot is released once the resolved branch sits in the execute-to-commit register
    assign free_chkp_o     = br_done_q && ex_valid_i;
    assign rf_we_o         = cm_valid_i && cm_write_i && !cm_xcpt_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_q    <= 1'b0;
            serial_q  <= 1'b0;
            br_ex_q   <= 1'b0;
            br_done_q <= 1'b0;
        end else begin
            xcpt_q    <= xcpt_q ? 1'b0 : cm_xcpt_i;
            br_ex_q   <= do_checkpoint_o;
            br_done_q <= br_ex_q && !ex_mispredict_i && !xcpt_flush;
            if (xcpt_flush) begin
                serial_q <= 1'b0;
            end else if (id_serial_i && !flush_id_o) begin
                serial_q <= 1'b1;
            end else if (cm_valid_i && cm_serial_i) begin
                serial_q <= 1'b0;
            end
        end
    end

endmodule

// File: src/core_pipe_top.sv
// top level of the four-stage core, connects the stages to the control unit
`timescale 1ns/1ps
`include "core_config.svh"

module core_pipe_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  isa_pkg::instr_t             instr_i,
    input  logic                        halt_i,
    output logic [`PC_W-1:0]            fetch_pc_o,
    output logic                        commit_valid_o,
    output logic [`PC_W-1:0]            commit_pc_o,
    output logic                        rf_we_o,
    output logic [isa_pkg::REG_W-1:0]   rf_waddr_o,
    output logic [isa_pkg::IMM_W-1:0]   rf_wdata_o
);
    import isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic             if_valid, id_valid, ex_valid;
    logic [`PC_W-1:0] if_pc, id_pc, ex_pc;
    instr_t           if_instr, id_instr, ex_instr;
    chkp_t            id_chkp, ex_chkp;

    logic             id_jal, id_is_br, id_serial, chkp_empty;
    logic [`PC_W-1:0] id_jal_target, ex_target;
    logic             ex_mispredict;
    logic             cm_xcpt, cm_serial, cm_write;

    logic             stall_if, stall_id, flush_if, flush_id, flush_ex;
    logic             do_checkpoint, do_recover, free_chkp;
    next_pc_sel_e     next_pc_sel;
    jump_src_e        jump_src;

    fetch_stage u_fetch (
        .clk_i, .rstn_i, .instr_i,
        .stall_if_i(stall_if), .flush_if_i(flush_if),
        .next_pc_sel_i(next_pc_sel), .jump_src_i(jump_src),
        .id_jal_target_i(id_jal_target), .ex_target_i(ex_target),
        .fetch_pc_o,
        .if_valid_o(if_valid), .if_pc_o(if_pc), .if_instr_o(if_instr)
    );

    decode_stage u_decode (
        .clk_i, .rstn_i,
        .if_valid_i(if_valid), .if_pc_i(if_pc), .if_instr_i(if_instr),
        .stall_id_i(stall_id), .flush_id_i(flush_id),
        .do_checkpoint_i(do_checkpoint), .do_recover_i(do_recover),
        .free_chkp_i(free_chkp), .recover_chkp_i(ex_chkp),
        .id_jal_o(id_jal), .id_jal_target_o(id_jal_target),
        .id_is_br_o(id_is_br), .id_serial_o(id_serial), .chkp_empty_o(chkp_empty),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_instr_o(id_instr), .id_chkp_o(id_chkp)
    );

    exec_stage u_exec (
        .clk_i, .rstn_i,
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_instr_i(id_instr), .id_chkp_i(id_chkp),
        .flush_ex_i(flush_ex),
        .ex_valid_o(ex_valid), .ex_mispredict_o(ex_mispredict), .ex_target_o(ex_target),
        .ex_chkp_o(ex_chkp), .ex_pc_o(ex_pc), .ex_instr_o(ex_instr)
    );

    commit_stage u_commit (
        .clk_i, .rstn_i,
        .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_instr_i(ex_instr), .rf_we_i(rf_we_o),
        .cm_valid_o(commit_valid_o), .cm_xcpt_o(cm_xcpt), .cm_serial_o(cm_serial),
        .cm_write_o(cm_write), .commit_pc_o, .rf_waddr_o, .rf_wdata_o
    );

    control_unit u_ctrl (
        .clk_i, .rstn_i, .halt_i,
        .id_jal_i(id_jal), .id_is_br_i(id_is_br), .id_serial_i(id_serial),
        .chkp_empty_i(chkp_empty), .ex_valid_i(ex_valid), .ex_mispredict_i(ex_mispredict),
        .cm_valid_i(commit_valid_o), .cm_xcpt_i(cm_xcpt), .cm_serial_i(cm_serial),
        .cm_write_i(cm_write),
        .stall_if_o(stall_if), .stall_id_o(stall_id),
        .flush_if_o(flush_if), .flush_id_o(flush_id), .flush_ex_o(flush_ex),
        .next_pc_sel_o(next_pc_sel), .jump_src_o(jump_src),
        .do_checkpoint_o(do_checkpoint), .do_recover_o(do_recover),
        .free_chkp_o(free_chkp), .rf_we_o
    );

endmodule

// File: sim/core_pipe_chk.sv
// protocol checks on the control unit attached to every control_unit instance with bind
`timescale 1ns/1ps

module core_pipe_chk (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic stall_id_i,
    input  logic flush_id_i,
    input  logic do_checkpoint_i,
    input  logic chkp_empty_i,
    input  logic cm_xcpt_i,
    input  logic xcpt_q_i
);

    // number of assertion failures so far
    int unsigned failures = 0;

    // a decode slot is either held or killed, never both
    decode_hold_or_kill: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(stall_id_i && flush_id_i)
    ) else begin
        failures++;
        $error("decode stall and decode flush high in the same cycle");
    end

    // no allocation from an exhausted pool
    chkp_alloc_when_free: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(do_checkpoint_i && chkp_empty_i)
    ) else begin
        failures++;
        $error("checkpoint allocated while the pool is empty");
    end

    // an ecall at commit raises the exception state for exactly one cycle
    xcpt_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cm_xcpt_i |=> xcpt_q_i ##1 !xcpt_q_i
    ) else begin
        failures++;
        $error("exception state did not follow the ecall as a one-cycle pulse");
    end

endmodule

// File: sim/tb_core_pipe.sv
// directed testbench for the four-stage core that serves instruction memory and checks commits
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core_pipe;
    import isa_pkg::*;

    localparam int ROM_DEPTH  = 1 << `PC_W;
    localparam int WAIT_LIMIT = 40;

    logic                clk_i;
    logic                rstn_i;
    instr_t              instr_i;
    logic                halt_i;
    logic [`PC_W-1:0]    fetch_pc_o;
    logic                commit_valid_o;
    logic [`PC_W-1:0]    commit_pc_o;
    logic                rf_we_o;
    logic [REG_W-1:0]    rf_waddr_o;
    logic [IMM_W-1:0]    rf_wdata_o;

    instr_t              rom [ROM_DEPTH];
    logic [31:0]         lfsr_q;

    // expected commit list from the reference interpreter
    logic [`PC_W-1:0]    exp_pc [$];
    logic                exp_we [$];
    logic [REG_W-1:0]    exp_rd [$];
    logic [IMM_W-1:0]    exp_data [$];

    int                  tests_run;
    int                  tests_failed;
    int                  err_total;
    int                  timeouts;

    core_pipe_top u_core_pipe_top (
        .clk_i(clk_i),
        .rstn_i(rstn_i),
        .instr_i(instr_i),
        .halt_i(halt_i),
        .fetch_pc_o(fetch_pc_o),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o(commit_pc_o),
        .rf_we_o(rf_we_o),
        .rf_waddr_o(rf_waddr_o),
        .rf_wdata_o(rf_wdata_o)
    );

    bind control_unit core_pipe_chk u_chk (
        .clk_i(clk_i),
        .rstn_i(rstn_i),
        .stall_id_i(stall_id_o),
        .flush_id_i(flush_id_o),
        .do_checkpoint_i(do_checkpoint_o),
        .chkp_empty_i(chkp_empty_i),
        .cm_xcpt_i(cm_xcpt_i),
        .xcpt_q_i(xcpt_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // instruction memory answers the pc on the falling edge
    always @(negedge clk_i) begin
        instr_i <= rom[fetch_pc_o];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [IMM_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[IMM_W-2:0], lfsr_q[0]};
        end
    endtask

    function automatic instr_t encode(input opcode_e opc, input logic [2:0] rd,
                                      input logic [9:0] imm);
        return {opc, rd, imm};
    endfunction

    // background is an alu op that writes its own address into reg addr mod 8
    task automatic fill_rom;
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[a] = encode(OP_ALU, 3'(a), 10'(a));
        end
    endtask

    task automatic put_random_alu(input int addr);
        logic [IMM_W-1:0] imm;
        draw_bits(IMM_W, imm);
        rom[addr] = encode(OP_ALU, 3'(addr), imm);
    endtask

    // walks the program in architectural order for n commits
    task automatic build_expected(input int n);
        logic [`PC_W-1:0] pc;
        instr_t           ins;
        opcode_e          opc;
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
        pc = '0;
        for (int i = 0; i < n; i++) begin
            ins = rom[pc];
            opc = opcode_e'(ins[15:13]);
            exp_pc.push_back(pc);
            exp_we.push_back((opc == OP_ALU) || (opc == OP_CSR));
            exp_rd.push_back(ins[12:10]);
            exp_data.push_back(ins[9:0]);
            case (opc)
                OP_BR:    pc = ins[9] ? ins[8:0] : pc + 1'b1;
                OP_JAL:   pc = ins[8:0];
                OP_ECALL: pc = `TRAP_VEC;
                default:  pc = pc + 1'b1;
            endcase
        end
    endtask

    task automatic apply_reset;
        @(negedge clk_i);
        rstn_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;
    endtask

    // redir_edge counts rising edges after reset release, 0 means no fetch check
    task automatic check_commits(input string name, input int redir_edge,
                                 input logic [`PC_W-1:0] redir_pc);
        int   errs;
        int   cycles;
        int   edges;
        logic lost;
        errs  = 0;
        edges = 0;
        lost  = 1'b0;
        for (int i = 0; i < exp_pc.size() && !lost; i++) begin
            cycles = 0;
            do begin
                @(negedge clk_i);
                cycles++;
                edges++;
                if (edges == redir_edge && fetch_pc_o !== redir_pc) begin
                    errs++;
                    $display("[ERROR] %s edge %0d fetch_pc_o: got %h, expected %h",
                             name, edges, fetch_pc_o, redir_pc);
                end
            end while (!commit_valid_o && cycles < WAIT_LIMIT);
            if (!commit_valid_o) begin
                lost = 1'b1;
                $display("%s: no commit within %0d cycles, waiting for commit %0d",
                         name, WAIT_LIMIT, i);
            end else begin
                if (commit_pc_o !== exp_pc[i]) begin
                    errs++;
                    $display("[ERROR] %s commit %0d commit_pc_o: got %h, expected %h",
                             name, i, commit_pc_o, exp_pc[i]);
                end
                if (rf_we_o !== exp_we[i]) begin
                    errs++;
                    $display("[ERROR] %s commit %0d rf_we_o: got %h, expected %h",
                             name, i, rf_we_o, exp_we[i]);
                end
                if (exp_we[i] && rf_waddr_o !== exp_rd[i]) begin
                    errs++;
                    $display("[ERROR] %s commit %0d rf_waddr_o: got %h, expected %h",
                             name, i, rf_waddr_o, exp_rd[i]);
                end
                if (exp_we[i] && rf_wdata_o !== exp_data[i]) begin
                    errs++;
                    $display("[ERROR] %s commit %0d rf_wdata_o: got %h, expected %h",
                             name, i, rf_wdata_o, exp_data[i]);
                end
            end
        end
        tests_run++;
        err_total += errs;
        if (lost) begin
            timeouts++;
        end
        if (lost || errs != 0) begin
            tests_failed++;
            $display("test %s: failed, %0d mismatches", name, errs);
        end else begin
            $display("test %s: ok, %0d commits in order", name, exp_pc.size());
        end
    endtask

    task automatic straight_alu_in_order;
        fill_rom();
        for (int a = 0; a < 8; a++) begin
            put_random_alu(a);
        end
        build_expected(10);
        apply_reset();
        check_commits("straight_alu", 0, '0);
    endtask

    task automatic taken_branch_skips_wrong_path;
        fill_rom();
        put_random_alu(0);
        put_random_alu(1);
        rom[2] = encode(OP_BR, 3'd0, {1'b1, 9'h040});
        // wrong path behind the branch
        put_random_alu(3);
        put_random_alu(4);
        for (int a = 'h40; a < 'h43; a++) begin
            put_random_alu(a);
        end
        build_expected(6);
        apply_reset();
        // branch at 2 sits in execute after edge 4 and fetch moves on edge 5
        check_commits("taken_branch", 2 + 3, 9'h040);
    endtask

    task automatic jal_skips_next;
        fill_rom();
        put_random_alu(0);
        rom[1] = encode(OP_JAL, 3'd0, {1'b0, 9'h060});
        put_random_alu(2);
        put_random_alu(3);
        put_random_alu('h60);
        put_random_alu('h61);
        build_expected(5);
        apply_reset();
        // jal at 1 sits in decode after edge 2 and fetch moves on edge 3
        check_commits("jal", 1 + 2, 9'h060);
    endtask

    task automatic ecall_traps;
        fill_rom();
        put_random_alu(0);
        put_random_alu(1);
        rom[2] = encode(OP_ECALL, 3'd0, 10'd0);
        for (int a = 3; a < 6; a++) begin
            put_random_alu(a);
        end
        for (int a = `TRAP_VEC; a < `TRAP_VEC + 3; a++) begin
            put_random_alu(a);
        end
        build_expected(6);
        apply_reset();
        // ecall at 2 commits on edge 6 and the trap pc shows two edges later
        check_commits("ecall", 2 + 6, `TRAP_VEC);
    endtask

    task automatic fence_csr_serialize;
        logic [IMM_W-1:0] imm;
        fill_rom();
        put_random_alu(0);
        rom[1] = encode(OP_FENCE, 3'd0, 10'd0);
        put_random_alu(2);
        draw_bits(IMM_W, imm);
        rom[3] = encode(OP_CSR, 3'd5, imm);
        put_random_alu(4);
        put_random_alu(5);
        build_expected(7);
        apply_reset();
        check_commits("fence_csr", 0, '0);
    endtask

    // more branches in a row than the pool has slots
    task automatic branch_chain_stalls;
        logic [IMM_W-1:0] tgt;
        fill_rom();
        for (int a = 0; a < `CHKP_NUM + 2; a++) begin
            draw_bits(9, tgt);
            rom[a] = encode(OP_BR, 3'd0, {1'b0, tgt[8:0]});
        end
        for (int a = `CHKP_NUM + 2; a < `CHKP_NUM + 6; a++) begin
            put_random_alu(a);
        end
        build_expected(`CHKP_NUM + 7);
        apply_reset();
        check_commits("branch_chain", 0, '0);
    endtask

    initial begin
        rstn_i       = 1'b0;
        halt_i       = 1'b0;
        instr_i      = '0;
        lfsr_q       = 32'hd21f_9287;
        tests_run    = 0;
        tests_failed = 0;
        err_total    = 0;
        timeouts     = 0;
        fill_rom();
        straight_alu_in_order();
        taken_branch_skips_wrong_path();
        jal_skips_next();
        ecall_traps();
        fence_csr_serialize();
        branch_chain_stalls();
        $display("summary: %0d tests, %0d failed, %0d mismatches, %0d timeouts, %0d assert errors",
                 tests_run, tests_failed, err_total, timeouts,
                 u_core_pipe_top.u_ctrl.u_chk.failures);
        if (tests_failed == 0 && u_core_pipe_top.u_ctrl.u_chk.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/exec_stage.sv
src/commit_stage.sv
src/control_unit.sv
src/core_pipe_top.sv
sim/core_pipe_chk.sv
sim/tb_core_pipe.sv

// File: Bender.yml
package:
  name: core_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/pipe_ctrl_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/exec_stage.sv
      - src/commit_stage.sv
      - src/control_unit.sv
      - src/core_pipe_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/core_pipe_chk.sv
      - sim/tb_core_pipe.sv
